//--- verilog/i2c_bringup_defs.svh
`ifndef I2C_BRINGUP_DEFS_SVH
`define I2C_BRINGUP_DEFS_SVH

// one switch select, then a write/read pair per eeprom byte
`define I2C_INIT_LENGTH 21

// address bytes as they go out on the bus, r/w bit included
`define I2C_SWITCH_ADDR 8'he8
`define I2C_EEPROM_WR 8'ha8
`define I2C_EEPROM_RD 8'ha9

// nack retries the master tolerates per command
`define I2C_NACK_DEFAULT 4'h2

// switch channel the identity eeprom hangs on
`define I2C_EEPROM_CHANNEL 8

// mac upper 3, mac lower 3, ip 4
`define EEPROM_ID_BYTES 10

// fallback identity when the eeprom is not trusted
`define DEFAULT_MAC 48'h503eaa059701
`define DEFAULT_IP 32'hc0a801e0

`endif

//--- verilog/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// plain view: how the master sees a command
	typedef struct packed {
		logic        stop;
		logic [3:0]  nack;
		logic [31:0] data;
	} i2c_raw_t;

	// same word read as a bus switch select
	typedef struct packed {
		logic        stop;
		logic [3:0]  nack;
		logic [7:0]  dev;     // device address byte
		logic [7:0]  channel; // switch channel byte
		logic [15:0] low;     // zero on a switch select
	} i2c_switch_t;

	// 37-bit command word, decoded either way
	typedef union packed {
		i2c_raw_t    raw;
		i2c_switch_t sw;
	} i2c_cmd_u;

	// data returned by the master with its completion strobe
	typedef logic [31:0] i2c_result_t;

endpackage

`default_nettype wire

//--- verilog/netid_pkg.sv
`default_nettype none

package netid_pkg;

	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip_t;

	// byte order as read from the eeprom, first byte on top
	typedef struct packed {
		logic [23:0] mac_upper;
		logic [23:0] mac_lower;
		ip_t         ip;
	} eeprom_id_t;

endpackage

`default_nettype wire

//--- verilog/i2c_record_if.sv
`timescale 1ns/1ps
`default_nettype none

interface i2c_record_if;
	import i2c_pkg::*;

	logic        record_valid; // single cycle per finished command
	i2c_cmd_u    record_cmd;
	i2c_result_t record_data;
	logic        record_init;  // command came from the initial list

	modport producer (
		output record_valid,
		output record_cmd,
		output record_data,
		output record_init
	);

	modport consumer (
		input record_valid,
		input record_cmd,
		input record_data,
		input record_init
	);

endinterface

`default_nettype wire

//--- verilog/i2c_init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_bringup_defs.svh"

module i2c_init_sequencer (
	input  logic              hw,
	input  logic              poweronreset,
	input  logic              live_stop,
	input  logic [3:0]        live_nack,
	input  logic [31:0]       live_data,
	input  logic              live_start,
	input  logic              result_strobe,
	output i2c_pkg::i2c_cmd_u cmd,
	output logic              cmd_start,
	output logic              cmd_init,
	output logic              busy,
	output logic              init_done
);
	import i2c_pkg::*;

	localparam int LAST = `I2C_INIT_LENGTH - 1;
	localparam int IDX_W = $clog2(`I2C_INIT_LENGTH);

	logic [IDX_W-1:0] index;   // position in the initial list
	logic             waiting; // a command is out, strobe pending
	logic             last_init;

	// entry idx of the initial list
	// 0 selects the eeprom channel, odd entries write the byte address,
	// even entries read one byte back
	function automatic i2c_cmd_u list_entry(input logic [IDX_W-1:0] idx);
		i2c_cmd_u   c;
		logic [7:0] addr;
		addr = 8'((idx - 1'b1) >> 1);
		c.raw.nack = `I2C_NACK_DEFAULT;
		if (idx == '0) begin
			c.raw.stop = 1'b1;
			c.raw.data = {`I2C_SWITCH_ADDR, 8'(`I2C_EEPROM_CHANNEL), 16'h0000};
		end else if (idx[0]) begin
			c.raw.stop = 1'b0; // repeated start into the read
			c.raw.data = {`I2C_EEPROM_WR, addr, 16'h0000};
		end else begin
			c.raw.stop = 1'b1;
			c.raw.data = {`I2C_EEPROM_RD, 24'h000000};
		end
		return c;
	endfunction

	assign last_init = (index == IDX_W'(LAST));
	assign busy = waiting;

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			index     <= '0;
			waiting   <= 1'b0;
			cmd_start <= 1'b0;
			cmd_init  <= 1'b0;
			init_done <= 1'b0;
		end else begin
			cmd_start <= 1'b0;
			if (!waiting && !init_done) begin
				// first entry, right out of reset
				cmd       <= list_entry(index);
				cmd_start <= 1'b1;
				cmd_init  <= 1'b1;
				waiting   <= 1'b1;
			end else if (waiting && result_strobe) begin
				if (cmd_init && !last_init) begin
					// chain straight into the next entry
					index     <= index + 1'b1;
					cmd       <= list_entry(index + 1'b1);
					cmd_start <= 1'b1;
				end else begin
					waiting   <= 1'b0;
					init_done <= init_done | cmd_init;
				end
			end else if (init_done && !waiting && live_start) begin
				cmd.raw   <= {live_stop, live_nack, live_data}; // host command as is
				cmd_start <= 1'b1;
				cmd_init  <= 1'b0;
				waiting   <= 1'b1;
			end
		end
	end

	// a start never stretches past one cycle
	a_start_pulse: assert property (
		@(posedge hw) disable iff (poweronreset)
		cmd_start |=> !cmd_start
	) else $error("cmd_start held for more than one cycle");

	// master only answers commands that are outstanding
	a_strobe_expected: assert property (
		@(posedge hw) disable iff (poweronreset)
		result_strobe |-> waiting
	) else $error("result_strobe with no command outstanding");

endmodule

`default_nettype wire

//--- verilog/i2c_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_result_stage (
	input  logic                 hw,
	input  logic                 poweronreset,
	input  i2c_pkg::i2c_cmd_u    cmd,
	input  logic                 cmd_start,
	input  logic                 cmd_init,
	input  logic                 result_strobe,
	input  i2c_pkg::i2c_result_t result_data,
	i2c_record_if.producer       rec
);
	import i2c_pkg::*;

	i2c_cmd_u pend_cmd;  // command now on the bus
	logic     pend_init;

	always_ff @(posedge hw) begin
		if (cmd_start) begin
			pend_cmd  <= cmd;
			pend_init <= cmd_init;
		end
	end

	always_ff @(posedge hw) begin
		if (poweronreset)
			rec.record_valid <= 1'b0;
		else
			rec.record_valid <= result_strobe;
	end

	// pair the strobe with the command that caused it
	always_ff @(posedge hw) begin
		if (result_strobe) begin
			rec.record_cmd  <= pend_cmd;
			rec.record_data <= result_data;
			rec.record_init <= pend_init;
		end
	end

	a_record_single: assert property (
		@(posedge hw) disable iff (poweronreset)
		rec.record_valid |=> !rec.record_valid
	) else $error("record_valid lasted two cycles");

endmodule

`default_nettype wire

//--- verilog/eeprom_id_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_bringup_defs.svh"

module eeprom_id_capture (
	input  logic                 hw,
	input  logic                 poweronreset,
	i2c_record_if.consumer       rec,
	input  logic                 load_macip,
	input  logic                 use_default,
	output netid_pkg::mac_t      mac,
	output netid_pkg::ip_t       ip,
	output logic                 host_result_valid,
	output i2c_pkg::i2c_result_t host_result_data
);
	import netid_pkg::*;

	eeprom_id_t       identity;
	logic [7:0]       channel;  // last channel selected on the switch
	logic             switch_sel;
	logic             id_byte;
	logic             live_rec;

	// a switch select as the initial list builds it
	assign switch_sel = rec.record_valid && rec.record_cmd.sw.stop &&
		(rec.record_cmd.sw.nack == `I2C_NACK_DEFAULT) &&
		(rec.record_cmd.sw.dev == `I2C_SWITCH_ADDR) &&
		(rec.record_cmd.sw.low == 16'h0000);

	// read bit set in the address byte, eeprom channel selected
	assign id_byte = rec.record_valid && rec.record_init &&
		rec.record_cmd.raw.data[24] &&
		(channel == 8'(`I2C_EEPROM_CHANNEL));

	assign live_rec = rec.record_valid && !rec.record_init;

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			channel           <= 8'h00;
			identity          <= '0;
			mac               <= '0;
			ip                <= '0;
			host_result_valid <= 1'b0;
		end else begin
			if (switch_sel)
				channel <= rec.record_cmd.sw.channel;
			if (id_byte)
				identity <= {identity[71:0], rec.record_data[7:0]}; // first byte ends on top
			host_result_valid <= live_rec;
			if (load_macip) begin
				if (use_default) begin
					mac <= `DEFAULT_MAC;
					ip  <= `DEFAULT_IP;
				end else begin
					mac <= {identity.mac_upper, identity.mac_lower};
					ip  <= identity.ip;
				end
			end
		end
	end

	// live results back to the host
	always_ff @(posedge hw) begin
		if (live_rec)
			host_result_data <= rec.record_data;
	end

endmodule

`default_nettype wire

//--- verilog/i2c_bringup_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bringup_top (
	input  logic                 hw,
	input  logic                 poweronreset,
	// to the external i2c master
	output logic                 cmd_stop,
	output logic [3:0]           cmd_nack,
	output logic [31:0]          cmd_data,
	output logic                 cmd_start,
	input  logic                 result_strobe,
	input  i2c_pkg::i2c_result_t result_data,
	// host register port
	input  logic                 live_stop,
	input  logic [3:0]           live_nack,
	input  logic [31:0]          live_data,
	input  logic                 live_start,
	output logic                 busy,
	output logic                 host_result_valid,
	output i2c_pkg::i2c_result_t host_result_data,
	// identity
	input  logic                 load_macip,
	input  logic                 use_default,
	output netid_pkg::mac_t      mac,
	output netid_pkg::ip_t       ip,
	output logic                 init_done
);
	import i2c_pkg::*;

	i2c_cmd_u seq_cmd;
	logic     seq_init; // issued command belongs to the initial list

	i2c_record_if rec_if ();

	assign cmd_stop = seq_cmd.raw.stop;
	assign cmd_nack = seq_cmd.raw.nack;
	assign cmd_data = seq_cmd.raw.data;

	i2c_init_sequencer i_i2c_init_sequencer (
		.hw            (hw),
		.poweronreset  (poweronreset),
		.live_stop     (live_stop),
		.live_nack     (live_nack),
		.live_data     (live_data),
		.live_start    (live_start),
		.result_strobe (result_strobe),
		.cmd           (seq_cmd),
		.cmd_start     (cmd_start),
		.cmd_init      (seq_init),
		.busy          (busy),
		.init_done     (init_done)
	);

	i2c_result_stage i_i2c_result_stage (
		.hw            (hw),
		.poweronreset  (poweronreset),
		.cmd           (seq_cmd),
		.cmd_start     (cmd_start),
		.cmd_init      (seq_init),
		.result_strobe (result_strobe),
		.result_data   (result_data),
		.rec           (rec_if.producer)
	);

	eeprom_id_capture i_eeprom_id_capture (
		.hw                (hw),
		.poweronreset      (poweronreset),
		.rec               (rec_if.consumer),
		.load_macip        (load_macip),
		.use_default       (use_default),
		.mac               (mac),
		.ip                (ip),
		.host_result_valid (host_result_valid),
		.host_result_data  (host_result_data)
	);

endmodule

`default_nettype wire

//--- dv/tb_i2c_bringup.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_bringup_defs.svh"

module tb_i2c_bringup;

	localparam int LIVE_COUNT = 4;
	localparam int STIM_LIVE = 12; // first live command word in the file
	localparam int TOTAL_CMDS = 2 * `I2C_INIT_LENGTH + LIVE_COUNT + 1;
	localparam int CYCLE_LIMIT = TOTAL_CMDS * 12 + 200;

	logic        hw;
	logic        poweronreset;
	logic        cmd_stop;
	logic [3:0]  cmd_nack;
	logic [31:0] cmd_data;
	logic        cmd_start;
	logic        result_strobe;
	logic [31:0] result_data;
	logic        live_stop;
	logic [3:0]  live_nack;
	logic [31:0] live_data;
	logic        live_start;
	logic        busy;
	logic        host_result_valid;
	logic [31:0] host_result_data;
	logic        load_macip;
	logic        use_default;
	logic [47:0] mac;
	logic [31:0] ip;
	logic        init_done;

	logic [39:0] stim [0:19];
	logic [36:0] expect_cmds [$];
	logic [36:0] seen_cmds [$]; // every start the master saw
	logic [31:0] live_resp;     // master answer to the next live command
	int          host_results = 0;
	int          cycles = 0;
	int          checks_done = 0;
	int          failed_checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_base;
	string       test_name;

	i2c_bringup_top i_i2c_bringup_top (
		.hw                (hw),
		.poweronreset      (poweronreset),
		.cmd_stop          (cmd_stop),
		.cmd_nack          (cmd_nack),
		.cmd_data          (cmd_data),
		.cmd_start         (cmd_start),
		.result_strobe     (result_strobe),
		.result_data       (result_data),
		.live_stop         (live_stop),
		.live_nack         (live_nack),
		.live_data         (live_data),
		.live_start        (live_start),
		.busy              (busy),
		.host_result_valid (host_result_valid),
		.host_result_data  (host_result_data),
		.load_macip        (load_macip),
		.use_default       (use_default),
		.mac               (mac),
		.ip                (ip),
		.init_done         (init_done)
	);

	initial begin
		hw = 1'b0;
		forever #4 hw = ~hw;
	end

	always @(negedge hw)
		if (host_result_valid)
			host_results = host_results + 1;

	always @(posedge hw) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] eeprom_byte(input logic [7:0] addr);
		if (int'(addr) < `EEPROM_ID_BYTES)
			return {24'h000000, stim[int'(addr)][7:0]};
		return 32'h00000000; // nothing stored past the identity
	endfunction

	// command level i2c master with random latency
	initial begin : master_model
		logic [36:0] c;
		logic [31:0] resp;
		logic [7:0]  last_addr;
		logic        pending;
		int unsigned delay;
		void'($urandom(32'hdb95));
		result_strobe = 1'b0;
		result_data = 32'h0;
		resp = 32'h0;
		last_addr = 8'h00;
		pending = 1'b0;
		delay = 0;
		forever begin
			@(negedge hw);
			result_strobe = 1'b0;
			if (poweronreset) begin
				pending = 1'b0;
			end else begin
				if (pending) begin
					if (delay <= 1) begin
						result_strobe = 1'b1;
						result_data = resp;
						pending = 1'b0;
					end else
						delay = delay - 1;
				end
				if (cmd_start) begin
					c = {cmd_stop, cmd_nack, cmd_data};
					seen_cmds.push_back(c);
					if (init_done)
						resp = live_resp;
					else if (c[31:24] == `I2C_EEPROM_WR) begin
						last_addr = c[23:16]; // byte address of the next read
						resp = 32'h0;
					end else if (c[31:24] == `I2C_EEPROM_RD)
						resp = eeprom_byte(last_addr);
					else
						resp = 32'h0;
					delay = 2 + ($urandom % 8); // 2 to 9 cycles
					pending = 1'b1;
				end
			end
		end
	end

	task automatic check_equal(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks_done = checks_done + 1;
		assert (act === exp) else begin
			failed_checks = failed_checks + 1;
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_base = failed_checks;
	endtask

	task automatic finish_test();
		tests_run = tests_run + 1;
		if (failed_checks == test_base)
			$display("test %s: ok", test_name);
		else begin
			tests_failed = tests_failed + 1;
			$display("test %s: %0d checks failed", test_name, failed_checks - test_base);
		end
	endtask

	// switch select, then address write and byte read per eeprom byte
	task automatic build_init_list();
		expect_cmds.delete();
		expect_cmds.push_back({1'b1, `I2C_NACK_DEFAULT, `I2C_SWITCH_ADDR,
			8'(`I2C_EEPROM_CHANNEL), 16'h0000});
		for (int n = 0; n < `EEPROM_ID_BYTES; n++) begin
			expect_cmds.push_back({1'b0, `I2C_NACK_DEFAULT, `I2C_EEPROM_WR, 8'(n), 16'h0000});
			expect_cmds.push_back({1'b1, `I2C_NACK_DEFAULT, `I2C_EEPROM_RD, 24'h000000});
		end
	endtask

	task automatic check_init_list(input int base);
		check_equal("init_cmd_count", 64'(`I2C_INIT_LENGTH), 64'(seen_cmds.size() - base));
		for (int i = 0; i < expect_cmds.size() && base + i < seen_cmds.size(); i++)
			check_equal($sformatf("init_cmd_%0d", i), 64'(expect_cmds[i]),
				64'(seen_cmds[base + i]));
	endtask

	task automatic load_and_check(input logic dflt);
		logic [47:0] mac_exp;
		logic [31:0] ip_exp;
		mac_exp = {stim[0][7:0], stim[1][7:0], stim[2][7:0],
			stim[3][7:0], stim[4][7:0], stim[5][7:0]};
		ip_exp = {stim[6][7:0], stim[7][7:0], stim[8][7:0], stim[9][7:0]};
		if (dflt) begin
			mac_exp = `DEFAULT_MAC;
			ip_exp = `DEFAULT_IP;
		end else begin
			check_equal("file_mac", 64'(stim[10][47:0]), 64'(mac_exp));
			check_equal("file_ip", 64'(stim[11][31:0]), 64'(ip_exp));
		end
		use_default = dflt;
		load_macip = 1'b1;
		@(negedge hw);
		load_macip = 1'b0;
		check_equal("mac", 64'(mac_exp), 64'(mac)); // updated one cycle after the load
		check_equal("ip", 64'(ip_exp), 64'(ip));
	endtask

	task automatic run_live(input int idx, input logic hold_start);
		logic [36:0] c;
		logic [31:0] r;
		int          base;
		int          hbase;
		c = stim[STIM_LIVE + 2 * idx][36:0];
		r = stim[STIM_LIVE + 2 * idx + 1][31:0];
		base = seen_cmds.size();
		hbase = host_results;
		live_resp = r;
		{live_stop, live_nack, live_data} = c;
		live_start = 1'b1;
		@(negedge hw);
		check_equal("busy_after_start", 64'd1, 64'(busy)); // command now outstanding
		while (hold_start && busy) begin
			live_data = ~live_data; // retries while busy must not start
			@(negedge hw);
		end
		live_start = 1'b0;
		while (!host_result_valid)
			@(negedge hw);
		check_equal("host_result_data", 64'(r), 64'(host_result_data));
		check_equal("busy_after_result", 64'd0, 64'(busy));
		repeat (4) @(negedge hw);
		check_equal("start_count", 64'(base + 1), 64'(seen_cmds.size()));
		check_equal("host_result_count", 64'(hbase + 1), 64'(host_results));
		if (seen_cmds.size() > base)
			check_equal("live_cmd", 64'(c), 64'(seen_cmds[base]));
	endtask

	initial begin
		int base;
		int hbase;
		poweronreset = 1'b1;
		live_stop = 1'b0;
		live_nack = 4'h0;
		live_data = 32'h0;
		live_start = 1'b0;
		load_macip = 1'b0;
		use_default = 1'b0;
		live_resp = 32'h0;
		$readmemh("dv/i2c_bringup_stimulus.txt", stim);
		build_init_list();
		repeat (10) @(negedge hw);
		poweronreset = 1'b0;

		start_test("init_sequence");
		while (!init_done)
			@(negedge hw);
		repeat (3) @(negedge hw);
		check_init_list(0);
		finish_test();

		start_test("load_eeprom_identity");
		load_and_check(1'b0);
		finish_test();

		start_test("load_default_identity");
		load_and_check(1'b1);
		finish_test();

		start_test("live_commands");
		for (int i = 0; i < LIVE_COUNT; i++)
			run_live(i, 1'b0);
		finish_test();

		start_test("live_start_while_busy");
		run_live(LIVE_COUNT - 1, 1'b1);
		finish_test();

		start_test("reset_rerun");
		poweronreset = 1'b1;
		repeat (3) @(negedge hw);
		check_equal("init_done", 64'd0, 64'(init_done));
		check_equal("busy", 64'd0, 64'(busy));
		check_equal("cmd_start", 64'd0, 64'(cmd_start));
		check_equal("host_result_valid", 64'd0, 64'(host_result_valid));
		check_equal("mac", 64'd0, 64'(mac));
		check_equal("ip", 64'd0, 64'(ip));
		repeat (7) @(negedge hw);
		base = seen_cmds.size();
		hbase = host_results;
		poweronreset = 1'b0;
		live_start = 1'b1; // held through the whole initial list
		while (!init_done)
			@(negedge hw);
		live_start = 1'b0;
		repeat (4) @(negedge hw);
		check_init_list(base);
		check_equal("host_results", 64'(hbase), 64'(host_results));
		load_and_check(1'b0);
		finish_test();

		$display("%0d tests run, %0d failed, %0d of %0d checks failed",
			tests_run, tests_failed, failed_checks, checks_done);
		if (failed_checks == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/i2c_bringup_stimulus.txt
// words 0-9: eeprom bytes at byte addresses 0-9, words 10-11: expected mac and ip
// words 12-19: live command as {stop, nack, data}, then the master response
// mac upper
00
0a
35
// mac lower
12
34
56
// ip
c0
a8
01
0a
000a35123456
c0a8010a
// live: switch select of channel 4
12e8040000
00000004
03a8050000
000000a5
12a9000000
0000005c
0f12345678
deadbeef

//--- flist.f
+incdir+verilog
verilog/i2c_pkg.sv
verilog/netid_pkg.sv
verilog/i2c_record_if.sv
verilog/i2c_init_sequencer.sv
verilog/i2c_result_stage.sv
verilog/eeprom_id_capture.sv
verilog/i2c_bringup_top.sv
dv/tb_i2c_bringup.sv

//--- run_sim.sh
#!/bin/sh
# verilator build and run from the project root, pass is the pass line in sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_i2c_bringup \
	-o tb_i2c_bringup_sim > build.log 2>&1 &&
./obj_dir/tb_i2c_bringup_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
